/* logic/gf_pkg.sv */
package gf_pkg;

	// operation codes written to CTRL[1:0].
	typedef enum logic [1:0] {
		MUL        = 2'd0,
		MUL_SERIAL = 2'd1,
		SQUARE     = 2'd2,
		INVERT     = 2'd3
	} gf_op_e;

	// register map, byte offsets.
	localparam logic [4:0] ADDR_OPA    = 5'h00;
	localparam logic [4:0] ADDR_OPB    = 5'h04;
	localparam logic [4:0] ADDR_CTRL   = 5'h08;
	localparam logic [4:0] ADDR_STATUS = 5'h0C;
	localparam logic [4:0] ADDR_RESULT = 5'h10;

	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	localparam int POLY_W = 11; // wide enough for x^10.

	// primitive polynomial of degree m, x^m term included.
	function automatic logic [POLY_W-1:0] gf_poly(input int unsigned m);
		logic [POLY_W-1:0] p;
		case (m)
			3: p = 11'h00B; // x^3 + x + 1.
			4: p = 11'h013; // x^4 + x + 1.
			5: p = 11'h025; // x^5 + x^2 + 1.
			6: p = 11'h043; // x^6 + x + 1.
			7: p = 11'h089; // x^7 + x^3 + 1.
			8: p = 11'h11D; // x^8 + x^4 + x^3 + x^2 + 1.
			9: p = 11'h211; // x^9 + x^4 + 1.
			10: p = 11'h409; // x^10 + x^3 + 1.
			default: p = '0; // unsupported degree.
		endcase
		return p;
	endfunction

endpackage

/* logic/gf_mul_par.sv */
module gf_mul_par #(
	parameter int M = 8
) (
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] product
);
	localparam logic [gf_pkg::POLY_W-1:0] POLY_FULL = gf_pkg::gf_poly(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0]; // x^m term dropped.

	logic [M-1:0] row [M]; // row i is a * x^i mod p.
	wire  [M-1:0] col [M]; // transposed matrix.

	assign row[0] = a;

	for (genvar i = 1; i < M; i++) begin : g_row
		assign row[i] = {row[i-1][M-2:0], 1'b0} ^ (POLY & {M{row[i-1][M-1]}});
	end

	// each product bit is the inner product of one column with b.
	for (genvar j = 0; j < M; j++) begin : g_col
		for (genvar i = 0; i < M; i++) begin : g_bit
			assign col[j][i] = row[i][j];
		end
		assign product[j] = ^(col[j] & b);
	end

endmodule

/* logic/gf_mul_serial.sv */
module gf_mul_serial #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic         busy,
	output logic         done,
	output logic [M-1:0] product
);
	localparam logic [gf_pkg::POLY_W-1:0] POLY_FULL = gf_pkg::gf_poly(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0];
	localparam int CW = $clog2(M + 1);

	logic [M-1:0] a_q;
	logic [M-1:0] b_q;
	logic [M-1:0] acc;
	logic [M-1:0] acc_next;
	logic [CW-1:0] cnt;

	// horner step, msb of b first.
	assign acc_next = {acc[M-2:0], 1'b0} ^ (POLY & {M{acc[M-1]}}) ^ (a_q & {M{b_q[M-1]}});

	assign done = busy && (cnt == CW'(1)); // last run cycle.
	assign product = acc_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt <= CW'(M);
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= a;
			b_q <= b;
			acc <= '0;
		end else if (busy) begin
			acc <= acc_next;
			b_q <= {b_q[M-2:0], 1'b0};
		end
	end

	// the sequencer only starts an idle unit.
	a_start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* logic/gf_inverter.sv */
module gf_inverter #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic [M-1:0] a,
	output logic         busy,
	output logic         done,
	output logic [M-1:0] inverse
);
	localparam int CW = $clog2(M + 1);
	localparam logic [M-1:0] ONE = M'(1);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ITERATE
	} state_e;

	state_e state;
	logic [M-1:0] a_q;
	logic [M-1:0] sq;
	logic [M-1:0] acc;
	logic [M-1:0] sq_in;
	logic [M-1:0] sq_next;
	logic [M-1:0] acc_next;
	logic [CW-1:0] cnt;

	// a^(2^m - 2) = a^2 * a^4 * ... * a^(2^(m-1)).
	assign sq_in = (state == LOAD) ? a_q : sq;

	gf_mul_par #(.M(M)) i_square (
		.a(sq_in),
		.b(sq_in),
		.product(sq_next)
	);

	gf_mul_par #(.M(M)) i_acc_mul (
		.a(acc),
		.b(sq),
		.product(acc_next)
	);

	assign busy = (state != IDLE);
	assign done = (state == ITERATE) && (cnt == CW'(1));
	assign inverse = acc_next; // zero in gives zero, sq stays 0.

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: if (start)
					state <= LOAD;
				LOAD: begin
					state <= ITERATE;
					cnt <= CW'(M - 1);
				end
				default: begin
					cnt <= cnt - 1'b1;
					if (done)
						state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			a_q <= a;
		if (state == LOAD) begin
			sq <= sq_next; // a squared.
			acc <= ONE;
		end else if (state == ITERATE) begin
			sq <= sq_next;
			acc <= acc_next;
		end
	end

	// load cycle, then m-1 iterations, then idle.
	a_done_drops_busy: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> ##(M-1) done ##1 !busy);

endmodule

/* logic/gf_op_sequencer.sv */
module gf_op_sequencer #(
	parameter int M = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  gf_pkg::gf_op_e  op,
	input  logic [M-1:0]    opa,
	input  logic [M-1:0]    opb,
	output logic [M-1:0]    mul_a,
	output logic [M-1:0]    mul_b,
	input  logic [M-1:0]    mul_product,
	output logic            busy,
	output logic            done,
	output logic [M-1:0]    result
);
	typedef enum logic [1:0] {
		IDLE,
		WAIT_PAR,
		WAIT_UNIT
	} state_e;

	state_e state;
	gf_pkg::gf_op_e op_q;
	logic [M-1:0] opa_q;
	logic [M-1:0] opb_q;
	logic accept;
	logic ser_start;
	logic ser_busy;
	logic ser_done;
	logic [M-1:0] ser_product;
	logic inv_start;
	logic inv_busy;
	logic inv_done;
	logic [M-1:0] inv_result;
	logic unit_busy;
	logic unit_done;
	logic [M-1:0] unit_result;

	assign accept = start && (state == IDLE);
	assign ser_start = accept && (op == gf_pkg::MUL_SERIAL);
	assign inv_start = accept && (op == gf_pkg::INVERT);

	// shared parallel multiplier, squaring feeds A twice.
	assign mul_a = opa_q;
	assign mul_b = (op_q == gf_pkg::SQUARE) ? opa_q : opb_q;

	assign unit_busy = (op_q == gf_pkg::INVERT) ? inv_busy : ser_busy;
	assign unit_done = (op_q == gf_pkg::INVERT) ? inv_done : ser_done;
	assign unit_result = (op_q == gf_pkg::INVERT) ? inv_result : ser_product;

	assign busy = (state != IDLE);

	gf_mul_serial #(.M(M)) i_mul_serial (
		.clk(clk),
		.reset(reset),
		.start(ser_start),
		.a(opa),
		.b(opb),
		.busy(ser_busy),
		.done(ser_done),
		.product(ser_product)
	);

	gf_inverter #(.M(M)) i_inverter (
		.clk(clk),
		.reset(reset),
		.start(inv_start),
		.a(opa),
		.busy(inv_busy),
		.done(inv_done),
		.inverse(inv_result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			done <= 1'b0;
			op_q <= gf_pkg::MUL;
			result <= '0;
		end else begin
			case (state)
				IDLE: if (accept) begin
					done <= 1'b0; // sticky until the next start.
					op_q <= op;
					if (op == gf_pkg::MUL_SERIAL || op == gf_pkg::INVERT)
						state <= WAIT_UNIT;
					else
						state <= WAIT_PAR;
				end
				WAIT_PAR: begin
					result <= mul_product;
					done <= 1'b1;
					state <= IDLE;
				end
				default: if (unit_done) begin
					result <= unit_result;
					done <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			opa_q <= opa;
			opb_q <= opb;
		end
	end

	a_op_defined: assert property (@(posedge clk) disable iff (reset)
		start |-> op inside {gf_pkg::MUL, gf_pkg::MUL_SERIAL, gf_pkg::SQUARE, gf_pkg::INVERT});

	// the selected unit stays busy until it reports done.
	a_unit_busy: assert property (@(posedge clk) disable iff (reset)
		state == WAIT_UNIT |-> unit_busy);

endmodule

/* logic/gf_axil_regs.sv */
module gf_axil_regs #(
	parameter int M = 8
) (
	input  logic           clk,
	input  logic           reset,
	input  logic [31:0]    awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  logic [31:0]    wdata,
	input  logic [3:0]     wstrb,
	input  logic           wvalid,
	output logic           wready,
	output logic [1:0]     bresp,
	output logic           bvalid,
	input  logic           bready,
	input  logic [31:0]    araddr,
	input  logic           arvalid,
	output logic           arready,
	output logic [31:0]    rdata,
	output logic [1:0]     rresp,
	output logic           rvalid,
	input  logic           rready,
	output logic           start,
	output gf_pkg::gf_op_e op,
	output logic [M-1:0]   opa,
	output logic [M-1:0]   opb,
	input  logic           busy,
	input  logic           done,
	input  logic [M-1:0]   result
);
	logic wr_hs;
	logic rd_hs;
	logic [31:0] wmask;
	logic [31:0] opa_merge;
	logic [31:0] opb_merge;

	assign wr_hs = awvalid && awready && wvalid && wready;
	assign rd_hs = arvalid && arready;

	assign wmask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
	assign opa_merge = ({{(32-M){1'b0}}, opa} & ~wmask) | (wdata & wmask);
	assign opb_merge = ({{(32-M){1'b0}}, opb} & ~wmask) | (wdata & wmask);

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= gf_pkg::RESP_OKAY;
			start <= 1'b0;
			op <= gf_pkg::MUL;
			opa <= '0;
			opb <= '0;
		end else begin
			// aw and w are taken together, one write outstanding.
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			start <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp <= gf_pkg::RESP_OKAY;
				case (awaddr)
					{27'd0, gf_pkg::ADDR_OPA}: opa <= opa_merge[M-1:0];
					{27'd0, gf_pkg::ADDR_OPB}: opb <= opb_merge[M-1:0];
					{27'd0, gf_pkg::ADDR_CTRL}: begin
						if (busy || start)
							bresp <= gf_pkg::RESP_SLVERR; // op still running.
						else if (wstrb[0]) begin
							start <= 1'b1;
							op <= gf_pkg::gf_op_e'(wdata[1:0]);
						end
					end
					default: bresp <= gf_pkg::RESP_SLVERR; // read-only or unmapped.
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rresp <= gf_pkg::RESP_OKAY;
			rdata <= '0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_hs) begin
				rvalid <= 1'b1;
				rresp <= gf_pkg::RESP_OKAY;
				rdata <= '0;
				case (araddr)
					{27'd0, gf_pkg::ADDR_OPA}: rdata <= {{(32-M){1'b0}}, opa};
					{27'd0, gf_pkg::ADDR_OPB}: rdata <= {{(32-M){1'b0}}, opb};
					{27'd0, gf_pkg::ADDR_STATUS}: rdata <= {30'd0, done, busy};
					{27'd0, gf_pkg::ADDR_RESULT}: rdata <= {{(32-M){1'b0}}, result};
					default: rresp <= gf_pkg::RESP_SLVERR; // ctrl is write-only.
				endcase
			end
		end
	end

	a_b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

endmodule

/* logic/gf_coproc.sv */
module gf_coproc #(
	parameter int M = 8
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);
	logic start;
	gf_pkg::gf_op_e op;
	logic [M-1:0] opa;
	logic [M-1:0] opb;
	logic busy;
	logic done;
	logic [M-1:0] result;
	logic [M-1:0] mul_a;
	logic [M-1:0] mul_b;
	logic [M-1:0] mul_product;

	gf_axil_regs #(.M(M)) i_regs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.start(start),
		.op(op),
		.opa(opa),
		.opb(opb),
		.busy(busy),
		.done(done),
		.result(result)
	);

	gf_op_sequencer #(.M(M)) i_sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.opa(opa),
		.opb(opb),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_product(mul_product),
		.busy(busy),
		.done(done),
		.result(result)
	);

	gf_mul_par #(.M(M)) i_mul_par (
		.a(mul_a),
		.b(mul_b),
		.product(mul_product)
	);

endmodule

/* bench/gf_tb_clock.sv */
module gf_tb_clock (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // period 4.
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* bench/gf_tb.sv */
module gf_tb;
	localparam int M = 8;
	localparam int N_PAIRS = 50;
	localparam int OP_COUNT = 3 * N_PAIRS + 256 + 2; // ops over all tests.
	localparam int OP_CYCLES = 45; // typical op incl. bus gaps.
	localparam int TIMEOUT_CYCLES = 4 * OP_COUNT * OP_CYCLES;

	logic clk;
	logic reset;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic backpressure;
	int unsigned cycles = 0;
	logic [M-1:0] pair_a [N_PAIRS];
	logic [M-1:0] pair_b [N_PAIRS];

	gf_tb_clock i_clock (
		.clk(clk),
		.reset(reset)
	);

	gf_coproc #(.M(M)) i_gf_coproc (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout: the tests did not finish in %0d cycles", cycles));
	end

	// shift-and-add multiply, reduced by the field polynomial.
	function automatic logic [M-1:0] gf_model_mul(input logic [M-1:0] x, input logic [M-1:0] y);
		logic [gf_pkg::POLY_W-1:0] poly;
		logic [M-1:0] acc;
		logic [M-1:0] xs;
		poly = gf_pkg::gf_poly(M);
		acc = '0;
		xs = x;
		for (int i = 0; i < M; i++) begin
			if (y[i])
				acc = acc ^ xs;
			xs = xs[M-1] ? ({xs[M-2:0], 1'b0} ^ poly[M-1:0]) : {xs[M-2:0], 1'b0};
		end
		return acc;
	endfunction

	function automatic logic [M-1:0] random_elem();
		logic [31:0] r;
		r = $urandom;
		return r[M-1:0];
	endfunction

	function automatic logic [31:0] offset_addr(input logic [4:0] off);
		return {27'd0, off};
	endfunction

	task automatic bus_gap();
		if (backpressure)
			repeat ($urandom % 6) @(posedge clk);
	endtask

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bus_gap();
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		bus_gap();
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic write_expect(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axil_write(addr, data, strb, resp);
		expect_equal($sformatf("bresp @0x%0h", addr), resp, exp_resp);
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		expect_equal($sformatf("rresp @0x%0h", addr), resp, exp_resp);
		expect_equal($sformatf("rdata @0x%0h", addr), data, exp_data);
	endtask

	task automatic wait_done();
		logic [31:0] status;
		logic [1:0] resp;
		status = '0;
		while (!status[1]) begin
			axil_read(offset_addr(gf_pkg::ADDR_STATUS), status, resp);
			expect_equal("rresp STATUS", resp, gf_pkg::RESP_OKAY);
		end
		expect_equal("STATUS busy at done", status[0], 1'b0);
	endtask

	task automatic read_result(output logic [M-1:0] res);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(offset_addr(gf_pkg::ADDR_RESULT), data, resp);
		expect_equal("rresp RESULT", resp, gf_pkg::RESP_OKAY);
		res = data[M-1:0];
	endtask

	task automatic run_op(input gf_pkg::gf_op_e op, input logic [M-1:0] a,
			input logic [M-1:0] b, output logic [M-1:0] res);
		write_expect(offset_addr(gf_pkg::ADDR_OPA), a, 4'hF, gf_pkg::RESP_OKAY);
		write_expect(offset_addr(gf_pkg::ADDR_OPB), b, 4'hF, gf_pkg::RESP_OKAY);
		write_expect(offset_addr(gf_pkg::ADDR_CTRL), op, 4'hF, gf_pkg::RESP_OKAY);
		wait_done();
		read_result(res);
	endtask

	task automatic reset_values();
		read_expect(offset_addr(gf_pkg::ADDR_OPA), 32'h0, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_OPB), 32'h0, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_STATUS), 32'h0, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_RESULT), 32'h0, gf_pkg::RESP_OKAY);
	endtask

	task automatic mul_random_pairs();
		logic [M-1:0] res;
		for (int i = 0; i < N_PAIRS; i++) begin
			pair_a[i] = random_elem();
			pair_b[i] = random_elem();
		end
		pair_a[0] = '0;
		pair_b[1] = M'(1);
		backpressure = 1'b1;
		for (int i = 0; i < N_PAIRS; i++) begin
			run_op(gf_pkg::MUL, pair_a[i], pair_b[i], res);
			expect_equal("RESULT MUL", res, gf_model_mul(pair_a[i], pair_b[i]));
		end
		backpressure = 1'b0;
	endtask

	task automatic serial_and_square();
		logic [M-1:0] res;
		logic [M-1:0] a;
		for (int i = 0; i < N_PAIRS; i++) begin
			run_op(gf_pkg::MUL_SERIAL, pair_a[i], pair_b[i], res);
			expect_equal("RESULT MUL_SERIAL", res, gf_model_mul(pair_a[i], pair_b[i]));
		end
		for (int i = 0; i < N_PAIRS; i++) begin
			a = random_elem();
			run_op(gf_pkg::SQUARE, a, random_elem(), res); // opb is unused.
			expect_equal("RESULT SQUARE", res, gf_model_mul(a, a));
		end
	endtask

	task automatic invert_all_values();
		logic [M-1:0] res;
		backpressure = 1'b1;
		for (int a = 1; a < (1 << M); a++) begin
			run_op(gf_pkg::INVERT, M'(a), '0, res);
			expect_equal($sformatf("A*RESULT INVERT A=0x%0h", a), gf_model_mul(M'(a), res), 1);
		end
		backpressure = 1'b0;
		run_op(gf_pkg::INVERT, '0, '0, res);
		expect_equal("RESULT INVERT of zero", res, 0);
	endtask

	task automatic register_access();
		write_expect(offset_addr(gf_pkg::ADDR_OPA), 32'h5A, 4'hF, gf_pkg::RESP_OKAY);
		write_expect(offset_addr(gf_pkg::ADDR_OPB), 32'hC3, 4'hF, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_OPA), 32'h5A, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_OPB), 32'hC3, gf_pkg::RESP_OKAY);
		write_expect(offset_addr(gf_pkg::ADDR_OPA), 32'hFF, 4'hE, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_OPA), 32'h5A, gf_pkg::RESP_OKAY); // byte 0 masked.
		write_expect(32'h14, 32'h11, 4'hF, gf_pkg::RESP_SLVERR);
		write_expect(32'h40, 32'h22, 4'hF, gf_pkg::RESP_SLVERR);
		read_expect(32'h14, 32'h0, gf_pkg::RESP_SLVERR);
		read_expect(32'h1C, 32'h0, gf_pkg::RESP_SLVERR);
		read_expect(offset_addr(gf_pkg::ADDR_CTRL), 32'h0, gf_pkg::RESP_SLVERR);
		read_expect(offset_addr(gf_pkg::ADDR_OPA), 32'h5A, gf_pkg::RESP_OKAY);
		read_expect(offset_addr(gf_pkg::ADDR_OPB), 32'hC3, gf_pkg::RESP_OKAY);
	endtask

	task automatic ctrl_write_while_busy();
		logic [M-1:0] a;
		logic [M-1:0] res;
		a = 8'h53;
		write_expect(offset_addr(gf_pkg::ADDR_OPA), a, 4'hF, gf_pkg::RESP_OKAY);
		write_expect(offset_addr(gf_pkg::ADDR_CTRL), gf_pkg::INVERT, 4'hF, gf_pkg::RESP_OKAY);
		// inverter still running here.
		write_expect(offset_addr(gf_pkg::ADDR_CTRL), gf_pkg::MUL, 4'hF, gf_pkg::RESP_SLVERR);
		wait_done();
		read_result(res);
		expect_equal("A*RESULT INVERT while busy", gf_model_mul(a, res), 1);
	endtask

	initial begin
		int unsigned seed;
		int unsigned discard;
		seed = 12;
		discard = $urandom(seed);
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		backpressure = 1'b0;
		do @(posedge clk); while (reset);
		reset_values();
		mul_random_pairs();
		serial_and_square();
		invert_all_values();
		register_access();
		ctrl_write_while_busy();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tb.f */
logic/gf_pkg.sv
logic/gf_mul_par.sv
logic/gf_mul_serial.sv
logic/gf_inverter.sv
logic/gf_op_sequencer.sv
logic/gf_axil_regs.sv
logic/gf_coproc.sv
bench/gf_tb_clock.sv
bench/gf_tb.sv

/* Bender.yml */
package:
  name: gf_coproc

sources:
  - logic/gf_pkg.sv
  - logic/gf_mul_par.sv
  - logic/gf_mul_serial.sv
  - logic/gf_inverter.sv
  - logic/gf_op_sequencer.sv
  - logic/gf_axil_regs.sv
  - logic/gf_coproc.sv
  - target: test
    files:
      - bench/gf_tb_clock.sv
      - bench/gf_tb.sv
